//--- vlog.f
logic/bte_pkg.sv
logic/record_queue.sv
logic/error_injector.sv
logic/status_monitor.sv
logic/record_arbiter.sv
logic/record_serializer.sv
logic/uart_tx.sv
logic/bte_top.sv
test/tb_clock.sv
test/bte_properties.sv
test/bte_tb.sv

//--- test/bte_tb.sv
`timescale 1ns/1ps

module bte_tb
  import bte_pkg::*;
();

  localparam int START_TIMEOUT = 2 * FRAME_BITS * CLKS_PER_BIT;
  localparam int DRAIN_TIMEOUT = 8 * CHARS_PER_LINE * FRAME_BITS * CLKS_PER_BIT;
  localparam logic [127:0] HEX_DIGITS = "0123456789ABCDEF";

  typedef logic [8*CHARS_PER_LINE-1:0] line_t;

  // Error: hi is target, lo is code; status: hi is prime, lo is alive
  typedef struct packed {
    logic       is_error;
    logic [3:0] hi;
    logic [3:0] lo;
  } line_event_t;

  logic      clk;
  logic      arst_n;
  logic      start;
  target_t   target_select;
  err_code_t type_select;
  pair_t     prime;
  pair_t     alive;
  err_code_t error_cont_a;
  err_code_t error_cont_b;
  pair_t     error_cont_fdu;
  pair_t     prime_status;
  pair_t     alive_status;
  logic      serial;

  line_event_t exp_events[$];
  int          lines_pushed;
  int          lines_done;
  logic        stim_done;
  int          error_count;
  integer      seed = 32'h7168;
  pair_t       cur_prime;
  pair_t       cur_alive;

  tb_clock u_clock (
    .clk (clk)
  );

  bte_top dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .start          (start),
    .target_select  (target_select),
    .type_select    (type_select),
    .prime          (prime),
    .alive          (alive),
    .error_cont_a   (error_cont_a),
    .error_cont_b   (error_cont_b),
    .error_cont_fdu (error_cont_fdu),
    .prime_status   (prime_status),
    .alive_status   (alive_status),
    .serial         (serial)
  );

  // --------------------------------------------------
  // Reference model and compare tasks
  // --------------------------------------------------

  function automatic ascii_t hex_ascii(input logic [3:0] nib);
    return HEX_DIGITS[8*(15 - nib) +: 8];
  endfunction

  // Tag, zero digit, two payload digits, CR, LF
  function automatic line_t expected_line(input line_event_t ev);
    logic [3:0] tag;
    tag = ev.is_error ? REC_TAG_ERROR : REC_TAG_STATUS;
    return {hex_ascii(tag), hex_ascii(4'h0), hex_ascii(ev.hi), hex_ascii(ev.lo),
            ASCII_CR, ASCII_LF};
  endfunction

  task automatic fail_now(input string what);
    error_count++;
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_byte(input string name, input ascii_t got, input ascii_t exp);
    if (got !== exp) begin
      fail_now($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_error_code(input string name, input err_code_t got,
                                  input err_code_t exp);
    if (got !== exp) begin
      fail_now($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_pair(input string name, input pair_t got, input pair_t exp);
    if (got !== exp) begin
      fail_now($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // --------------------------------------------------
  // Serial receiver, sampled mid-bit on falling edges
  // --------------------------------------------------

  task automatic receive_byte(output ascii_t data);
    int waited;
    waited = 0;
    @(negedge clk);
    while (serial !== 1'b0) begin
      if (waited == START_TIMEOUT) begin
        fail_now("Timeout: no start bit appeared on serial");
      end
      waited++;
      @(negedge clk);
    end
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    if (serial !== 1'b0) begin
      fail_now("Framing error: start bit on serial did not stay low");
    end
    // LSB first
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[i] = serial;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    if (serial !== 1'b1) begin
      fail_now("Framing error: stop bit on serial was not high");
    end
  endtask

  // Pops expected events in order and matches each received line
  task automatic compare_lines();
    line_event_t ev;
    line_t       line;
    ascii_t      got;
    int          waited;
    logic        finished;
    finished = 1'b0;
    while (!finished) begin
      waited = 0;
      while (exp_events.size() == 0 && !stim_done) begin
        if (waited == DRAIN_TIMEOUT) begin
          fail_now("Timeout: no expected line was queued");
        end
        waited++;
        @(negedge clk);
      end
      if (exp_events.size() == 0) begin
        finished = 1'b1;
      end else begin
        ev   = exp_events.pop_front();
        line = expected_line(ev);
        for (int i = 0; i < CHARS_PER_LINE; i++) begin
          receive_byte(got);
          check_byte($sformatf("serial line %0d char %0d", lines_done, i), got,
                     line[8*(CHARS_PER_LINE-1-i) +: 8]);
        end
        lines_done++;
      end
    end
  endtask

  // --------------------------------------------------
  // Stimulus, driven on falling edges
  // --------------------------------------------------

  task automatic wait_lines_done();
    int waited;
    waited = 0;
    while (lines_done != lines_pushed) begin
      if (waited == DRAIN_TIMEOUT) begin
        fail_now("Timeout: expected lines never finished on serial");
      end
      waited++;
      @(negedge clk);
    end
  endtask

  // One-cycle start, returns on the edge after the latch
  task automatic pulse_start(input target_t t, input err_code_t c);
    start         = 1'b1;
    target_select = t;
    type_select   = c;
    exp_events.push_back('{is_error: 1'b1, hi: {2'b00, t}, lo: c});
    lines_pushed++;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic check_targets(input target_t t, input err_code_t c);
    check_error_code("error_cont_a", error_cont_a, (t == 2'd0) ? c : 4'h0);
    check_error_code("error_cont_b", error_cont_b, (t == 2'd1) ? c : 4'h0);
    check_pair("error_cont_fdu", error_cont_fdu, (t == 2'd2) ? c[1:0] : 2'b00);
  endtask

  task automatic drive_status(input pair_t p, input pair_t a);
    prime = p;
    alive = a;
    if ({p, a} != {cur_prime, cur_alive}) begin
      exp_events.push_back('{is_error: 1'b0, hi: {2'b00, p}, lo: {2'b00, a}});
      lines_pushed++;
    end
    cur_prime = p;
    cur_alive = a;
  endtask

  task automatic run_stimulus();
    logic [31:0] v;
    target_t     t;
    err_code_t   c;
    pair_t       p;
    pair_t       a;
    // Random targets, then an explicit target 3
    for (int i = 0; i < 9; i++) begin
      v = $random(seed);
      t = (i == 8) ? 2'd3 : v[5:4];
      c = v[3:0];
      pulse_start(t, c);
      check_targets(t, c);
      wait_lines_done();
    end
    // Status changes, each one distinct from the last
    for (int i = 0; i < 4; i++) begin
      v = $random(seed);
      p = v[3:2];
      a = v[1:0];
      if ({p, a} == {cur_prime, cur_alive}) begin
        a = ~a;
      end
      drive_status(p, a);
      repeat (3) @(negedge clk);
      check_pair("prime_status", prime_status, p);
      check_pair("alive_status", alive_status, a);
      wait_lines_done();
    end
    // Error and status in the same cycle, both held back by a busy line
    v = $random(seed);
    pulse_start(v[5:4], v[3:0]);
    check_targets(v[5:4], v[3:0]);
    v = $random(seed);
    p = ~cur_prime;
    prime = p;
    pulse_start(v[5:4], v[3:0]);
    // Status line expected after the error line
    drive_status(p, cur_alive);
    check_targets(v[5:4], v[3:0]);
    repeat (2) @(negedge clk);
    check_pair("prime_status", prime_status, cur_prime);
    check_pair("alive_status", alive_status, cur_alive);
    wait_lines_done();
    // Burst of three while the UART is busy
    for (int i = 0; i < 3; i++) begin
      v = $random(seed);
      pulse_start(v[5:4], v[3:0]);
      check_targets(v[5:4], v[3:0]);
    end
    wait_lines_done();
    stim_done = 1'b1;
  endtask

  initial begin
    arst_n        = 1'b0;
    start         = 1'b0;
    target_select = '0;
    type_select   = '0;
    prime         = '0;
    alive         = '0;
    cur_prime     = '0;
    cur_alive     = '0;
    lines_pushed  = 0;
    lines_done    = 0;
    stim_done     = 1'b0;
    error_count   = 0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    // Reset state
    check_bit("serial", serial, 1'b1);
    check_targets(2'd3, 4'h0);
    check_pair("prime_status", prime_status, 2'b00);
    check_pair("alive_status", alive_status, 2'b00);
    fork
      run_stimulus();
      compare_lines();
    join
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- test/bte_properties.sv
`timescale 1ns/1ps

module bte_properties
  import bte_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input logic      ascii_read,
  input logic      ascii_empty,
  input logic      record_write,
  input logic      serializer_busy,
  input err_code_t error_cont_a,
  input err_code_t error_cont_b,
  input pair_t     error_cont_fdu,
  input logic      serial,
  input logic      tx_sending
);

  // --------------------------------------------------
  // Handshake rules
  // --------------------------------------------------

  // UART pulls only when a byte is offered
  a_read_needs_data : assert property (@(posedge clk) disable iff (!arst_n)
    ascii_read |-> !ascii_empty)
    else $error("ascii_read while ascii_empty is high");

  // Arbiter issues only into an idle serializer
  a_write_when_idle : assert property (@(posedge clk) disable iff (!arst_n)
    record_write |-> !serializer_busy)
    else $error("record_write while serializer busy");

  // --------------------------------------------------
  // Output rules
  // --------------------------------------------------

  // One target at a time
  a_single_target : assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0({|error_cont_a, |error_cont_b, |error_cont_fdu}))
    else $error("more than one error output nonzero");

  // Line idles at mark level
  a_idle_high : assert property (@(posedge clk) disable iff (!arst_n)
    !tx_sending |-> serial)
    else $error("serial low while transmitter idle");

endmodule

bind bte_top bte_properties u_properties (
  .clk             (clk),
  .arst_n          (arst_n),
  .ascii_read      (ascii_read),
  .ascii_empty     (ascii_empty),
  .record_write    (record_write),
  .serializer_busy (serializer_busy),
  .error_cont_a    (error_cont_a),
  .error_cont_b    (error_cont_b),
  .error_cont_fdu  (error_cont_fdu),
  .serial          (serial),
  .tx_sending      (u_uart_tx.sending)
);

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter realtime PERIOD = 20ns
) (
  output logic clk
);

  // Free-running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

//--- logic/bte_top.sv
`timescale 1ns/1ps

module bte_top
  import bte_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      start,
  input  target_t   target_select,
  input  err_code_t type_select,
  input  pair_t     prime,
  input  pair_t     alive,
  output err_code_t error_cont_a,
  output err_code_t error_cont_b,
  output pair_t     error_cont_fdu,
  output pair_t     prime_status,
  output pair_t     alive_status,
  output logic      serial
);

  // Error path
  logic        error_push;
  error_rec_t  error_rec;
  logic        error_empty;
  error_rec_t  error_data;
  logic        error_read;

  // Status path
  logic        status_push;
  status_rec_t status_rec;
  logic        status_empty;
  status_rec_t status_data;
  logic        status_read;

  // Record and byte stream
  logic        record_write;
  record_t     record;
  logic        serializer_busy;
  ascii_t      ascii_data;
  logic        ascii_empty;
  logic        ascii_read;

  // --------------------------------------------------
  // Record sources
  // --------------------------------------------------

  error_injector u_error_injector (
    .clk            (clk),
    .arst_n         (arst_n),
    .start          (start),
    .target_select  (target_select),
    .type_select    (type_select),
    .error_cont_a   (error_cont_a),
    .error_cont_b   (error_cont_b),
    .error_cont_fdu (error_cont_fdu),
    .push           (error_push),
    .rec            (error_rec)
  );

  status_monitor u_status_monitor (
    .clk          (clk),
    .arst_n       (arst_n),
    .prime        (prime),
    .alive        (alive),
    .prime_status (prime_status),
    .alive_status (alive_status),
    .push         (status_push),
    .rec          (status_rec)
  );

  // --------------------------------------------------
  // Queues and arbitration
  // --------------------------------------------------

  record_queue #(
    .payload_t (error_rec_t)
  ) u_error_queue (
    .clk    (clk),
    .arst_n (arst_n),
    .push   (error_push),
    .wdata  (error_rec),
    .read   (error_read),
    .rdata  (error_data),
    .empty  (error_empty)
  );

  record_queue #(
    .payload_t (status_rec_t)
  ) u_status_queue (
    .clk    (clk),
    .arst_n (arst_n),
    .push   (status_push),
    .wdata  (status_rec),
    .read   (status_read),
    .rdata  (status_data),
    .empty  (status_empty)
  );

  record_arbiter u_record_arbiter (
    .clk             (clk),
    .arst_n          (arst_n),
    .error_empty     (error_empty),
    .error_data      (error_data),
    .status_empty    (status_empty),
    .status_data     (status_data),
    .serializer_busy (serializer_busy),
    .error_read      (error_read),
    .status_read     (status_read),
    .record_write    (record_write),
    .record          (record)
  );

  // --------------------------------------------------
  // Serial report
  // --------------------------------------------------

  record_serializer u_record_serializer (
    .clk          (clk),
    .arst_n       (arst_n),
    .record_write (record_write),
    .record       (record),
    .ascii_read   (ascii_read),
    .ascii_data   (ascii_data),
    .ascii_empty  (ascii_empty),
    .busy         (serializer_busy)
  );

  uart_tx u_uart_tx (
    .clk         (clk),
    .arst_n      (arst_n),
    .ascii_data  (ascii_data),
    .ascii_empty (ascii_empty),
    .ascii_read  (ascii_read),
    .serial      (serial)
  );

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
  import bte_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  ascii_t ascii_data,
  input  logic   ascii_empty,
  output logic   ascii_read,
  output logic   serial
);

  localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BIT_CNT_W-1:0]  STOP_BIT  = BIT_CNT_W'(FRAME_BITS - 1);

  logic                  sending;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [8:0]            shift;
  logic                  bit_end;

  // Pull a byte only between frames
  assign ascii_read = ~sending & ~ascii_empty;
  assign bit_end    = (baud_cnt == BAUD_LAST);

  // --------------------------------------------------
  // Frame control
  // --------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sending  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      serial   <= 1'b1;
    end else if (ascii_read) begin
      // Start bit goes out with the read
      sending  <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      serial   <= 1'b0;
    end else if (sending) begin
      if (bit_end) begin
        baud_cnt <= '0;
        if (bit_cnt == STOP_BIT) begin
          sending <= 1'b0;
          serial  <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          serial  <= shift[0];
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // Data LSB first, stop bit parked on top
  always_ff @(posedge clk) begin
    if (ascii_read) begin
      shift <= {1'b1, ascii_data};
    end else if (sending && bit_end) begin
      shift <= {1'b1, shift[8:1]};
    end
  end

endmodule

//--- logic/record_serializer.sv
`timescale 1ns/1ps

module record_serializer
  import bte_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    record_write,
  input  record_t record,
  input  logic    ascii_read,
  output ascii_t  ascii_data,
  output logic    ascii_empty,
  output logic    busy
);

  localparam logic [CHAR_IDX_W-1:0] IDX_LAST = CHAR_IDX_W'(CHARS_PER_LINE - 1);

  record_t               record_q;
  logic [CHAR_IDX_W-1:0] char_idx;

  // Upper-case hex digit
  function automatic ascii_t hex_char(input logic [3:0] nib);
    if (nib < 4'd10) begin
      return ASCII_ZERO + {4'h0, nib};
    end
    return ASCII_UPPER_A + {4'h0, nib - 4'd10};
  endfunction

  // Byte available for the whole line
  assign ascii_empty = ~busy;

  // --------------------------------------------------
  // Line sequencing
  // --------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      char_idx <= '0;
    end else if (record_write) begin
      busy     <= 1'b1;
      char_idx <= '0;
    end else if (ascii_read && busy) begin
      // Line done on the LF read
      if (char_idx == IDX_LAST) begin
        busy     <= 1'b0;
        char_idx <= '0;
      end else begin
        char_idx <= char_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (record_write) begin
      record_q <= record;
    end
  end

  // --------------------------------------------------
  // Character select
  // --------------------------------------------------

  // Most significant digit first
  always_comb begin
    case (char_idx)
      3'd0:    ascii_data = hex_char(record_q.tag);
      3'd1:    ascii_data = hex_char(record_q.digit2);
      3'd2:    ascii_data = hex_char(record_q.digit1);
      3'd3:    ascii_data = hex_char(record_q.digit0);
      3'd4:    ascii_data = ASCII_CR;
      default: ascii_data = ASCII_LF;
    endcase
  end

endmodule

//--- logic/record_arbiter.sv
`timescale 1ns/1ps

module record_arbiter
  import bte_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        error_empty,
  input  error_rec_t  error_data,
  input  logic        status_empty,
  input  status_rec_t status_data,
  input  logic        serializer_busy,
  output logic        error_read,
  output logic        status_read,
  output logic        record_write,
  output record_t     record
);

  logic can_issue;
  logic pick_error;
  logic pick_status;

  // Cycle of record_write is the hold-off while busy rises
  assign can_issue = ~serializer_busy & ~record_write;

  // Fixed priority, errors first
  assign pick_error  = can_issue & ~error_empty;
  assign pick_status = can_issue & error_empty & ~status_empty;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      error_read   <= 1'b0;
      status_read  <= 1'b0;
      record_write <= 1'b0;
    end else begin
      error_read   <= pick_error;
      status_read  <= pick_status;
      record_write <= pick_error | pick_status;
    end
  end

  // Tagged record, digit2 always zero
  always_ff @(posedge clk) begin
    if (pick_error) begin
      record.tag    <= REC_TAG_ERROR;
      record.digit2 <= 4'h0;
      record.digit1 <= {2'b00, error_data.target};
      record.digit0 <= error_data.code;
    end else if (pick_status) begin
      record.tag    <= REC_TAG_STATUS;
      record.digit2 <= 4'h0;
      record.digit1 <= {2'b00, status_data.prime};
      record.digit0 <= {2'b00, status_data.alive};
    end
  end

endmodule

//--- logic/status_monitor.sv
`timescale 1ns/1ps

module status_monitor
  import bte_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  pair_t       prime,
  input  pair_t       alive,
  output pair_t       prime_status,
  output pair_t       alive_status,
  output logic        push,
  output status_rec_t rec
);

  status_rec_t sync_meta;
  status_rec_t sync_stable;
  status_rec_t held;

  // Held copy is the exported status
  assign prime_status = held.prime;
  assign alive_status = held.alive;

  // Two-flop synchronizer, then compare against held copy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_meta   <= '0;
      sync_stable <= '0;
      held        <= '0;
      push        <= 1'b0;
    end else begin
      sync_meta   <= {prime, alive};
      sync_stable <= sync_meta;
      held        <= sync_stable;
      // Any bit change gives one record
      push        <= (sync_stable != held);
    end
  end

  // New values travel with the push
  always_ff @(posedge clk) begin
    if (sync_stable != held) begin
      rec <= sync_stable;
    end
  end

endmodule

//--- logic/error_injector.sv
`timescale 1ns/1ps

module error_injector
  import bte_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       start,
  input  target_t    target_select,
  input  err_code_t  type_select,
  output err_code_t  error_cont_a,
  output err_code_t  error_cont_b,
  output pair_t      error_cont_fdu,
  output logic       push,
  output error_rec_t rec
);

  // --------------------------------------------------
  // Target registers
  // --------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      error_cont_a   <= '0;
      error_cont_b   <= '0;
      error_cont_fdu <= '0;
      push           <= 1'b0;
    end else begin
      // One record per start cycle
      push <= start;
      if (start) begin
        // Only the selected target keeps a code
        error_cont_a   <= '0;
        error_cont_b   <= '0;
        error_cont_fdu <= '0;
        case (target_select)
          TARGET_CONT_A: error_cont_a   <= type_select;
          TARGET_CONT_B: error_cont_b   <= type_select;
          // FDU has a 2-bit error input
          TARGET_FDU:    error_cont_fdu <= type_select[1:0];
          // Target 3 leaves all cleared
          default:       error_cont_a   <= '0;
        endcase
      end
    end
  end

  // --------------------------------------------------
  // Record for the error queue
  // --------------------------------------------------

  // Valid alongside push
  always_ff @(posedge clk) begin
    if (start) begin
      rec.target <= target_select;
      rec.code   <= type_select;
    end
  end

endmodule

//--- logic/record_queue.sv
`timescale 1ns/1ps

module record_queue
  import bte_pkg::*;
#(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     push,
  input  payload_t wdata,
  input  logic     read,
  output payload_t rdata,
  output logic     empty
);

  localparam logic [QUEUE_PTR_W-1:0] PTR_LAST = QUEUE_PTR_W'(QUEUE_DEPTH - 1);

  payload_t               mem [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_PTR_W:0]   count;
  logic                   full;
  logic                   do_push;
  logic                   do_pop;

  assign full  = (count == (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
  assign empty = (count == '0);

  // Push into a full queue is lost
  assign do_push = push & ~full;
  assign do_pop  = read & ~empty;

  // Show-ahead head entry
  assign rdata = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      // Count moves only when one side acts alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- logic/bte_pkg.sv
package bte_pkg;

  // --------------------------------------------------
  // Payload and record types
  // --------------------------------------------------

  typedef logic [3:0] err_code_t;
  typedef logic [1:0] target_t;
  typedef logic [1:0] pair_t;
  typedef logic [7:0] ascii_t;

  // One injected error as queued
  typedef struct packed {
    target_t   target;
    err_code_t code;
  } error_rec_t;

  // One snapshot of the synchronized inputs
  typedef struct packed {
    pair_t prime;
    pair_t alive;
  } status_rec_t;

  // Tag digit leads, then three payload digits
  typedef struct packed {
    logic [3:0] tag;
    logic [3:0] digit2;
    logic [3:0] digit1;
    logic [3:0] digit0;
  } record_t;

  // --------------------------------------------------
  // Constants
  // --------------------------------------------------

  localparam target_t TARGET_CONT_A = 2'd0;
  localparam target_t TARGET_CONT_B = 2'd1;
  localparam target_t TARGET_FDU    = 2'd2;

  localparam logic [3:0] REC_TAG_ERROR  = 4'hE;
  localparam logic [3:0] REC_TAG_STATUS = 4'h5;

  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

  // Four hex digits plus line end
  localparam int CHARS_PER_LINE = 6;
  localparam int CHAR_IDX_W     = $clog2(CHARS_PER_LINE);

  localparam ascii_t ASCII_CR      = 8'h0D;
  localparam ascii_t ASCII_LF      = 8'h0A;
  localparam ascii_t ASCII_ZERO    = 8'h30;
  localparam ascii_t ASCII_UPPER_A = 8'h41;

  // 8N1 framing
  localparam int CLKS_PER_BIT = 16;
  localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
  localparam int FRAME_BITS   = 10;
  localparam int BIT_CNT_W    = $clog2(FRAME_BITS);

endpackage
